/* vlog.f */
hw/loader_pkg.sv
hw/download_decoder.sv
hw/rom_writer.sv
hw/populous_detect.sv
hw/cheat_code_assembler.sv
hw/cd_data_unpacker.sv
hw/loader_top.sv
testbench/tb_loader_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/1ps -f vlog.f --top-module tb_loader_top \
	-Mdir obj_dir -o sim_loader
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_loader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0

/* testbench/tb_loader_top.sv */
`timescale 1ns/1ps

module tb_loader_top;

	typedef enum logic [2:0] {
		K_START, K_END, K_CART, K_FILL,
		K_CODE, K_CD, K_SIZE, K_POP
	} entry_kind_t;

	logic                    clk_sys = 1'b0;
	logic                    reset;
	logic                    ioctl_download;
	loader_pkg::io_index_t   ioctl_index;
	loader_pkg::io_addr_t    ioctl_addr;
	loader_pkg::io_word_t    ioctl_dout;
	logic                    ioctl_wr;
	logic                    ioctl_wait;
	logic                    swap_bits;
	loader_pkg::rom_addr_t   mem_addr;
	loader_pkg::io_word_t    mem_data;
	logic                    mem_req_toggle;
	logic                    mem_ack_toggle = 1'b0;
	logic [11:0]             rom_size;
	logic                    console_sgx;
	logic [1:0]              populous;
	loader_pkg::cheat_code_t cheat_code;
	logic                    cheat_valid;
	logic                    cheat_clear;
	loader_pkg::cd_byte_t    cd_byte;
	logic                    cd_wr;
	logic                    cd_dm;

	// Memory model state
	logic                  ack_pending;
	int                    ack_delay;
	int unsigned           lcg_state;
	loader_pkg::rom_addr_t mem_last_addr;
	loader_pkg::io_word_t  mem_last_data;
	int                    mem_writes;

	// Stimulus table with one entry per test
	entry_kind_t           t_kind[$];
	string                 t_name[$];
	loader_pkg::io_index_t t_index[$];
	loader_pkg::io_addr_t  t_addr[$];
	loader_pkg::io_word_t  t_data[$];
	logic                  t_swap[$];
	logic [127:0]          t_exp[$];

	loader_pkg::cd_byte_t  cd_seen[$];
	loader_pkg::rom_addr_t next_addr;
	logic                  quiet_window;
	int                    errors;
	int                    test_err;
	int                    failed_tests;
	int                    cycle_cnt = 0;
	int                    cycle_limit;

	loader_top dut0 (.*);

	always #50 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Memory model with a pseudo random acknowledge delay
	////////////////////////////////////////////////////////////

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	always @(posedge clk_sys) begin
		if (reset) begin
			lcg_state = 32'd15;
			mem_ack_toggle <= 1'b0;
			ack_pending    <= 1'b0;
			ack_delay      <= 0;
			mem_writes     <= 0;
		end else if (ack_pending) begin
			if (ack_delay <= 1) begin
				mem_ack_toggle <= ~mem_ack_toggle;
				ack_pending    <= 1'b0;
			end else begin
				ack_delay <= ack_delay - 1;
			end
		end else if (mem_req_toggle != mem_ack_toggle) begin
			// 1 to 4 cycles until the acknowledge
			lcg_state = lcg_next(lcg_state);
			ack_delay     <= 1 + int'((lcg_state >> 16) % 4);
			ack_pending   <= 1'b1;
			mem_last_addr <= mem_addr;
			mem_last_data <= mem_data;
			mem_writes    <= mem_writes + 1;
		end
	end

	always @(negedge clk_sys) begin
		if (cd_wr) begin
			cd_seen.push_back(cd_byte);
		end
		if (quiet_window && ({ioctl_wait, cheat_valid, cd_wr} !== 3'b000)) begin
			$display("[FAIL] reset_quiet: expected 000, actual %b%b%b",
				ioctl_wait, cheat_valid, cd_wr);
			errors++;
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input loader_pkg::io_word_t exp_val,
		input loader_pkg::io_word_t act);
		if (act !== exp_val) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp_val, act);
			test_err++;
		end
	endtask

	task automatic check_addr(input string name, input loader_pkg::rom_addr_t exp_val,
		input loader_pkg::rom_addr_t act);
		if (act !== exp_val) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp_val, act);
			test_err++;
		end
	endtask

	task automatic check_code(input string name, input loader_pkg::cheat_code_t exp_val,
		input loader_pkg::cheat_code_t act);
		if (act !== exp_val) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp_val, act);
			test_err++;
		end
	endtask

	task automatic check_byte(input string name, input loader_pkg::cd_byte_t exp_val,
		input loader_pkg::cd_byte_t act);
		if (act !== exp_val) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp_val, act);
			test_err++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host side drivers
	////////////////////////////////////////////////////////////

	task automatic strobe_word(input loader_pkg::io_addr_t addr,
		input loader_pkg::io_word_t data, input logic swap);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		swap_bits  <= swap;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic cart_write(input string name, input loader_pkg::rom_addr_t addr,
		input loader_pkg::io_word_t data, input logic swap,
		input loader_pkg::io_word_t exp_word);
		int writes_before;
		writes_before = mem_writes;
		strobe_word({1'b0, addr}, data, swap);
		if (!ioctl_wait) begin
			$display("%s: ioctl_wait did not rise after the write strobe", name);
			test_err++;
		end
		check_addr(name, addr, mem_addr);
		// A cartridge word at address 0 also clears the cheat codes
		check_word(name, {15'd0, addr == 24'd0}, {15'd0, cheat_clear});
		do begin
			@(negedge clk_sys);
			if (!ioctl_wait && (mem_req_toggle != mem_ack_toggle)) begin
				$display("%s: ioctl_wait fell before the memory acknowledge", name);
				test_err++;
			end
		end while (ioctl_wait);
		if (mem_writes != writes_before + 1) begin
			$display("%s: memory saw %0d requests instead of one", name,
				mem_writes - writes_before);
			test_err++;
		end
		check_word(name, exp_word, mem_last_data);
		check_addr(name, addr, mem_last_addr);
		check_addr(name, addr + 24'd2, mem_addr);
		next_addr = addr + 24'd2;
	endtask

	function automatic loader_pkg::io_word_t fill_word(input loader_pkg::rom_addr_t a);
		return a[15:0] ^ a[23:8] ^ 16'h5A3C;
	endfunction

	// Unswapped filler words up to the next row under test
	task automatic fill_words(input string name, input loader_pkg::rom_addr_t last);
		loader_pkg::rom_addr_t a;
		a = next_addr;
		while (a < last) begin
			cart_write(name, a, fill_word(a), 1'b0, fill_word(a));
			a = a + 24'd2;
		end
	endtask

	task automatic code_write(input string name, input loader_pkg::io_addr_t addr,
		input loader_pkg::io_word_t data, input loader_pkg::cheat_code_t exp_code);
		logic last;
		logic first;
		last  = (addr == 25'd14);
		first = (addr == 25'd0);
		strobe_word(addr, data, 1'b0);
		check_word(name, {14'd0, last, first}, {14'd0, cheat_valid, cheat_clear});
		if (last) begin
			check_code(name, exp_code, cheat_code);
		end
		// Both strobes last one cycle
		@(negedge clk_sys);
		check_word(name, 16'h0000, {14'd0, cheat_valid, cheat_clear});
	endtask

	// Expected value holds cd_dm in bit 20, byte count in 17:16, bytes below
	task automatic cd_write(input string name, input loader_pkg::io_word_t data,
		input logic [20:0] exp_val);
		int n;
		n = int'(exp_val[17:16]);
		strobe_word(25'd0, data, 1'b0);
		// Low byte two cycles after the strobe, high byte two later
		repeat (4) @(negedge clk_sys);
		if (cd_seen.size() != n) begin
			$display("[FAIL] %s: expected %0d CD bytes, actual %0d", name, n, cd_seen.size());
			test_err++;
		end
		for (int k = 0; k < n && k < cd_seen.size(); k++) begin
			check_byte(name, (k == 0) ? exp_val[7:0] : exp_val[15:8], cd_seen[k]);
		end
		cd_seen.delete();
		check_word(name, {15'd0, exp_val[20]}, {15'd0, cd_dm});
	endtask

	task automatic run_entry(input entry_kind_t kind, input string name,
		input loader_pkg::io_index_t idx, input loader_pkg::io_addr_t addr,
		input loader_pkg::io_word_t data, input logic swap, input logic [127:0] exp_val);
		case (kind)
			K_START: begin
				@(posedge clk_sys);
				ioctl_index    <= idx;
				ioctl_download <= 1'b1;
				next_addr = '0;
				repeat (3) @(negedge clk_sys);
			end
			K_END: begin
				@(posedge clk_sys);
				ioctl_download <= 1'b0;
				repeat (2) @(negedge clk_sys);
			end
			K_CART: cart_write(name, addr[23:0], data, swap, exp_val[15:0]);
			K_FILL: fill_words(name, addr[23:0]);
			K_CODE: code_write(name, addr, data, exp_val);
			K_CD: cd_write(name, data, exp_val[20:0]);
			K_SIZE: check_word(name, exp_val[15:0], {3'b000, console_sgx, rom_size});
			K_POP: check_word(name, exp_val[15:0], {14'd0, populous});
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Test table
	////////////////////////////////////////////////////////////

	task automatic add_entry(input entry_kind_t kind, input string name,
		input loader_pkg::io_index_t idx, input loader_pkg::io_addr_t addr,
		input loader_pkg::io_word_t data, input logic swap, input logic [127:0] exp_val);
		t_kind.push_back(kind);
		t_name.push_back(name);
		t_index.push_back(idx);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_swap.push_back(swap);
		t_exp.push_back(exp_val);
	endtask

	task automatic build_table();
		// First image, SGX variant, signature rows 1F2 and 212 intact
		add_entry(K_START, "cart1_start", 8'h01, 25'h0, 16'h0, 1'b0, 128'h0);
		add_entry(K_POP, "pop_reset", 8'h00, 25'h0, 16'h0, 1'b0, 128'h3);
		add_entry(K_CART, "cart_w0_swap", 8'h00, 25'h0, 16'h1234, 1'b1, 128'h482C);
		add_entry(K_CART, "cart_w1", 8'h00, 25'h2, 16'hA5C3, 1'b0, 128'hA5C3);
		add_entry(K_CART, "cart_w2_swap", 8'h00, 25'h4, 16'h0F01, 1'b1, 128'hF080);
		add_entry(K_FILL, "fill_to_1f26", 8'h00, 25'h1F26, 16'h0, 1'b0, 128'h0);
		add_entry(K_CART, "sig_1f2_0", 8'h00, 25'h1F26, 16'h4F50, 1'b0, 128'h4F50);
		add_entry(K_CART, "sig_1f2_1", 8'h00, 25'h1F28, 16'h5550, 1'b0, 128'h5550);
		add_entry(K_CART, "sig_1f2_2", 8'h00, 25'h1F2A, 16'h4F4C, 1'b0, 128'h4F4C);
		add_entry(K_CART, "sig_1f2_3", 8'h00, 25'h1F2C, 16'h5355, 1'b0, 128'h5355);
		add_entry(K_FILL, "fill_to_2126", 8'h00, 25'h2126, 16'h0, 1'b0, 128'h0);
		add_entry(K_CART, "sig_212_0_swap", 8'h00, 25'h2126, 16'hF20A, 1'b1, 128'h4F50);
		add_entry(K_CART, "sig_212_1_swap", 8'h00, 25'h2128, 16'hAA0A, 1'b1, 128'h5550);
		add_entry(K_CART, "sig_212_2_swap", 8'h00, 25'h212A, 16'hF232, 1'b1, 128'h4F4C);
		add_entry(K_CART, "sig_212_3_swap", 8'h00, 25'h212C, 16'hCAAA, 1'b1, 128'h5355);
		add_entry(K_POP, "pop_both_rows", 8'h00, 25'h0, 16'h0, 1'b0, 128'h3);
		add_entry(K_END, "cart1_end", 8'h00, 25'h0, 16'h0, 1'b0, 128'h0);
		add_entry(K_SIZE, "size_sgx_1", 8'h00, 25'h0, 16'h0, 1'b0, 128'h1002);
		// Cheat file
		add_entry(K_START, "code_start", 8'hFF, 25'h0, 16'h0, 1'b0, 128'h0);
		add_entry(K_CODE, "code_w0", 8'hFF, 25'd0, 16'h0001, 1'b0, 128'h0);
		add_entry(K_CODE, "code_w2", 8'hFF, 25'd2, 16'h8000, 1'b0, 128'h0);
		add_entry(K_CODE, "code_w4", 8'hFF, 25'd4, 16'h3456, 1'b0, 128'h0);
		add_entry(K_CODE, "code_w6", 8'hFF, 25'd6, 16'h0012, 1'b0, 128'h0);
		add_entry(K_CODE, "code_w8", 8'hFF, 25'd8, 16'hBEEF, 1'b0, 128'h0);
		add_entry(K_CODE, "code_w10", 8'hFF, 25'd10, 16'hDEAD, 1'b0, 128'h0);
		add_entry(K_CODE, "code_w12", 8'hFF, 25'd12, 16'hCAFE, 1'b0, 128'h0);
		add_entry(K_CODE, "code_w14", 8'hFF, 25'd14, 16'hF00D, 1'b0,
			128'h80000001_00123456_DEADBEEF_F00DCAFE);
		add_entry(K_END, "code_end", 8'h00, 25'h0, 16'h0, 1'b0, 128'h0);
		// CD data, five bytes with data mode set
		add_entry(K_START, "cd_start", 8'h02, 25'h0, 16'h0, 1'b0, 128'h0);
		add_entry(K_CD, "cd_header", 8'h02, 25'h0, 16'h8005, 1'b0, 128'h100000);
		add_entry(K_CD, "cd_word0", 8'h02, 25'h0, 16'h2211, 1'b0, 128'h122211);
		add_entry(K_CD, "cd_word1", 8'h02, 25'h0, 16'h4433, 1'b0, 128'h124433);
		add_entry(K_CD, "cd_word2_odd", 8'h02, 25'h0, 16'h6655, 1'b0, 128'h110055);
		add_entry(K_CD, "cd_word3_past", 8'h02, 25'h0, 16'h8877, 1'b0, 128'h100000);
		add_entry(K_END, "cd_end", 8'h00, 25'h0, 16'h0, 1'b0, 128'h0);
		// Second image, base variant, one altered word in row 1F2
		add_entry(K_START, "cart2_start", 8'h00, 25'h0, 16'h0, 1'b0, 128'h0);
		add_entry(K_CART, "cart2_w0_swap", 8'h00, 25'h0, 16'h8001, 1'b1, 128'h0180);
		add_entry(K_FILL, "fill2_to_1f26", 8'h00, 25'h1F26, 16'h0, 1'b0, 128'h0);
		add_entry(K_CART, "sig2_0", 8'h00, 25'h1F26, 16'h4F50, 1'b0, 128'h4F50);
		add_entry(K_CART, "sig2_1", 8'h00, 25'h1F28, 16'h5550, 1'b0, 128'h5550);
		add_entry(K_CART, "sig2_2_altered", 8'h00, 25'h1F2A, 16'h4F4C, 1'b1, 128'hF232);
		add_entry(K_CART, "sig2_3", 8'h00, 25'h1F2C, 16'h5355, 1'b0, 128'h5355);
		add_entry(K_POP, "pop_one_cleared", 8'h00, 25'h0, 16'h0, 1'b0, 128'h2);
		add_entry(K_END, "cart2_end", 8'h00, 25'h0, 16'h0, 1'b0, 128'h0);
		add_entry(K_SIZE, "size_sgx_0", 8'h00, 25'h0, 16'h0, 1'b0, 128'h0001);
	endtask

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		swap_bits      = 1'b0;
		quiet_window   = 1'b1;
		errors         = 0;
		failed_tests   = 0;
		build_table();
		// Worst case per filler word plus a flat allowance per other entry
		cycle_limit = 64;
		foreach (t_kind[i]) begin
			cycle_limit += (t_kind[i] == K_FILL) ? int'(t_addr[i]) / 2 * 12 : 16;
		end

		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);
		quiet_window = 1'b0;
		@(negedge clk_sys);

		foreach (t_kind[i]) begin
			test_err = 0;
			run_entry(t_kind[i], t_name[i], t_index[i], t_addr[i], t_data[i], t_swap[i],
				t_exp[i]);
			errors += test_err;
			if (test_err != 0) begin
				failed_tests++;
			end
			$display("%-16s %s", t_name[i], (test_err == 0) ? "passed" : "failed");
		end

		$display("%0d tests run, %0d failed, %0d errors", t_kind.size(), failed_tests, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* hw/loader_top.sv */
`timescale 1ns/1ps

module loader_top #(
	parameter int ROM_ADDR_W = loader_pkg::ROM_ADDR_W
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  loader_pkg::io_index_t   ioctl_index,
	input  loader_pkg::io_addr_t    ioctl_addr,
	input  loader_pkg::io_word_t    ioctl_dout,
	input  logic                    ioctl_wr,
	output logic                    ioctl_wait,
	input  logic                    swap_bits,
	output loader_pkg::rom_addr_t   mem_addr,
	output loader_pkg::io_word_t    mem_data,
	output logic                    mem_req_toggle,
	input  logic                    mem_ack_toggle,
	output logic [11:0]             rom_size,
	output logic                    console_sgx,
	output logic [1:0]              populous,
	output loader_pkg::cheat_code_t cheat_code,
	output logic                    cheat_valid,
	output logic                    cheat_clear,
	output loader_pkg::cd_byte_t    cd_byte,
	output logic                    cd_wr,
	output logic                    cd_dm
);

	logic cart_download;
	logic code_download;
	logic cd_download;
	logic cart_start;
	logic cd_start;

	download_decoder u_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.cart_download  (cart_download),
		.code_download  (code_download),
		.cd_download    (cd_download),
		.cart_start     (cart_start),
		.cd_start       (cd_start)
	);

	rom_writer #(.ROM_ADDR_W(ROM_ADDR_W)) u_rom_writer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cart_download  (cart_download),
		.cart_start     (cart_start),
		.swap_bits      (swap_bits),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_dout     (ioctl_dout),
		.mem_ack_toggle (mem_ack_toggle),
		.ioctl_wait     (ioctl_wait),
		.mem_req_toggle (mem_req_toggle),
		.mem_addr       (mem_addr),
		.mem_data       (mem_data),
		.rom_size       (rom_size),
		.console_sgx    (console_sgx)
	);

	// Checks the words as they go out to memory
	populous_detect #(.ROM_ADDR_W(ROM_ADDR_W)) u_populous (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_start    (cart_start),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.populous      (populous)
	);

	cheat_code_assembler u_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.cheat_code    (cheat_code),
		.cheat_valid   (cheat_valid),
		.cheat_clear   (cheat_clear)
	);

	cd_data_unpacker u_cd_data (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cd_download (cd_download),
		.cd_start    (cd_start),
		.ioctl_wr    (ioctl_wr),
		.ioctl_dout  (ioctl_dout),
		.cd_byte     (cd_byte),
		.cd_wr       (cd_wr),
		.cd_dm       (cd_dm)
	);

endmodule

/* hw/cd_data_unpacker.sv */
`timescale 1ns/1ps

module cd_data_unpacker (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 cd_download,
	input  logic                 cd_start,
	input  logic                 ioctl_wr,
	input  loader_pkg::io_word_t ioctl_dout,
	output loader_pkg::cd_byte_t cd_byte,
	output logic                 cd_wr,
	output logic                 cd_dm
);

	typedef enum logic [1:0] {
		WAIT_HEADER,
		WAIT_WORD,
		EMIT_LOW,
		EMIT_HIGH
	} cd_state_t;

	cd_state_t            state;
	loader_pkg::cd_len_t  data_len;
	loader_pkg::cd_len_t  byte_cnt;
	loader_pkg::io_word_t data_word;
	logic                 cd_wr_en;

	assign cd_wr_en = cd_download && ioctl_wr;

	////////////////////////////////////////////////////////////
	// Header, then words split into two byte strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= WAIT_HEADER;
			data_len <= '0;
			byte_cnt <= '0;
			cd_wr    <= 1'b0;
			cd_dm    <= 1'b0;
		end else if (cd_start) begin
			state    <= WAIT_HEADER;
			data_len <= '0;
			byte_cnt <= '0;
			cd_wr    <= 1'b0;
		end else begin
			case (state)
				WAIT_HEADER: begin
					if (cd_wr_en) begin
						// Bit 15 is the data mode flag
						cd_dm    <= ioctl_dout[15];
						data_len <= ioctl_dout[14:0];
						byte_cnt <= '0;
						state    <= WAIT_WORD;
					end
				end
				WAIT_WORD: begin
					// Words past the length are dropped
					if (cd_wr_en && (byte_cnt < data_len)) begin
						data_word <= ioctl_dout;
						state     <= EMIT_LOW;
					end
				end
				EMIT_LOW: begin
					if (!cd_wr) begin
						cd_wr   <= 1'b1;
						cd_byte <= data_word[7:0];
					end else begin
						cd_wr    <= 1'b0;
						byte_cnt <= byte_cnt + 15'd1;
						// Odd length ends on a low byte
						state    <= (byte_cnt + 15'd1 >= data_len) ? WAIT_WORD : EMIT_HIGH;
					end
				end
				EMIT_HIGH: begin
					if (!cd_wr) begin
						cd_wr   <= 1'b1;
						cd_byte <= data_word[15:8];
					end else begin
						cd_wr    <= 1'b0;
						byte_cnt <= byte_cnt + 15'd1;
						state    <= WAIT_WORD;
					end
				end
				default: state <= WAIT_HEADER;
			endcase
		end
	end

endmodule

/* hw/cheat_code_assembler.sv */
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    code_download,
	input  logic                    cart_download,
	input  logic                    ioctl_wr,
	input  loader_pkg::io_addr_t    ioctl_addr,
	input  loader_pkg::io_word_t    ioctl_dout,
	output loader_pkg::cheat_code_t cheat_code,
	output logic                    cheat_valid,
	output logic                    cheat_clear
);

	logic code_wr;

	assign code_wr = code_download && ioctl_wr;

	////////////////////////////////////////////////////////////
	// Word placement with the low word of each field first
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= ioctl_dout;
				4'd2:  cheat_code[127:112] <= ioctl_dout;
				4'd4:  cheat_code[79:64]   <= ioctl_dout;
				4'd6:  cheat_code[95:80]   <= ioctl_dout;
				4'd8:  cheat_code[47:32]   <= ioctl_dout;
				4'd10: cheat_code[63:48]   <= ioctl_dout;
				4'd12: cheat_code[15:0]    <= ioctl_dout;
				4'd14: cheat_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word completes the code
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (ioctl_addr[3:0] == 4'd14);
			// Any new cart or cheat file drops the old codes
			cheat_clear <= (cart_download || code_download) && ioctl_wr && (ioctl_addr == '0);
		end
	end

endmodule

/* hw/populous_detect.sv */
`timescale 1ns/1ps

module populous_detect #(
	parameter int ROM_ADDR_W = 24
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cart_start,
	input  logic                  cart_download,
	input  logic                  ioctl_wr,
	input  loader_pkg::rom_addr_t mem_addr,
	input  loader_pkg::io_word_t  mem_data,
	output logic [1:0]            populous
);

	localparam logic [ROM_ADDR_W-5:0] PAGE_A = loader_pkg::POP_PAGE_A;
	localparam logic [ROM_ADDR_W-5:0] PAGE_B = loader_pkg::POP_PAGE_B;

	logic                 wr_q;
	logic                 page_hit;
	logic                 sig_offset;
	loader_pkg::io_word_t expect_word;

	// Row within either candidate page
	assign page_hit = (mem_addr[ROM_ADDR_W-1:4] == PAGE_A) ||
		(mem_addr[ROM_ADDR_W-1:4] == PAGE_B);

	always_comb begin
		sig_offset  = 1'b1;
		expect_word = '0;
		case (mem_addr[3:0])
			4'd6:    expect_word = loader_pkg::POP_SIG_0;
			4'd8:    expect_word = loader_pkg::POP_SIG_1;
			4'd10:   expect_word = loader_pkg::POP_SIG_2;
			4'd12:   expect_word = loader_pkg::POP_SIG_3;
			default: sig_offset  = 1'b0;
		endcase
	end

	// Data reaches mem_data one cycle after the host strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q     <= 1'b0;
			populous <= 2'b00;
		end else begin
			wr_q <= ioctl_wr && cart_download;
			if (cart_start) begin
				populous <= 2'b11;
			end else if (wr_q && page_hit && sig_offset && (mem_data != expect_word)) begin
				// Bit 13 picks which half of the image was checked
				populous[mem_addr[13]] <= 1'b0;
			end
		end
	end

endmodule

/* hw/rom_writer.sv */
`timescale 1ns/1ps

module rom_writer #(
	parameter int ROM_ADDR_W = 24
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cart_download,
	input  logic                  cart_start,
	input  logic                  swap_bits,
	input  logic                  ioctl_wr,
	input  loader_pkg::io_index_t ioctl_index,
	input  loader_pkg::io_word_t  ioctl_dout,
	input  logic                  mem_ack_toggle,
	output logic                  ioctl_wait,
	output logic                  mem_req_toggle,
	output loader_pkg::rom_addr_t mem_addr,
	output loader_pkg::io_word_t  mem_data,
	output logic [11:0]           rom_size,
	output logic                  console_sgx
);

	logic [ROM_ADDR_W-1:0] wr_addr;
	loader_pkg::io_word_t  swapped;
	loader_pkg::io_word_t  wr_word;
	logic                  cart_wr;
	logic                  ack_match;

	////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////

	// Bit order reversed inside each byte, bytes stay put
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			swapped[i]     = ioctl_dout[7-i];
			swapped[8 + i] = ioctl_dout[15-i];
		end
	end

	assign wr_word   = swap_bits ? swapped : ioctl_dout;
	assign cart_wr   = ioctl_wr && cart_download;
	assign ack_match = (mem_req_toggle == mem_ack_toggle);

	// Payload register for the pending request
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			mem_data <= wr_word;
		end
	end

	////////////////////////////////////////////////////////////
	// Request handshake and address
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait     <= 1'b0;
			mem_req_toggle <= 1'b0;
			wr_addr        <= '0;
			console_sgx    <= 1'b0;
		end else if (cart_start) begin
			wr_addr     <= '0;
			console_sgx <= ioctl_index[0];
		end else if (cart_wr) begin
			// Host is held off until the memory catches up
			ioctl_wait     <= 1'b1;
			mem_req_toggle <= ~mem_req_toggle;
		end else if (ioctl_wait && ack_match) begin
			ioctl_wait <= 1'b0;
			wr_addr    <= wr_addr + ROM_ADDR_W'(2);
		end
	end

	assign mem_addr = wr_addr;

	// Size in 4 KiB units
	assign rom_size = wr_addr[ROM_ADDR_W-1 -: 12];

endmodule

/* hw/download_decoder.sv */
`timescale 1ns/1ps

module download_decoder (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ioctl_download,
	input  loader_pkg::io_index_t ioctl_index,
	output logic                  cart_download,
	output logic                  code_download,
	output logic                  cd_download,
	output logic                  cart_start,
	output logic                  cd_start
);

	logic cart_prev;
	logic cd_prev;

	////////////////////////////////////////////////////////////
	// Index classification
	////////////////////////////////////////////////////////////

	// Indices 0 and 1 are the two console variants
	assign cart_download = ioctl_download && (ioctl_index[5:0] <= loader_pkg::IDX_CART_MAX);

	// Cheat file uses the all ones index
	assign code_download = ioctl_download && (&ioctl_index);

	assign cd_download = ioctl_download && (ioctl_index[5:0] == loader_pkg::IDX_CD_DATA);

	////////////////////////////////////////////////////////////
	// Start strobes on rising level
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_prev  <= 1'b0;
			cd_prev    <= 1'b0;
			cart_start <= 1'b0;
			cd_start   <= 1'b0;
		end else begin
			cart_prev  <= cart_download;
			cd_prev    <= cd_download;
			cart_start <= cart_download && !cart_prev;
			cd_start   <= cd_download && !cd_prev;
		end
	end

endmodule

/* hw/loader_pkg.sv */
package loader_pkg;

	////////////////////////////////////////////////////////////
	// Host stream types
	////////////////////////////////////////////////////////////

	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  io_index_t;
	typedef logic [24:0] io_addr_t;

	// Memory write address in bytes
	typedef logic [23:0] rom_addr_t;

	// Flags, address, compare, replace from top to bottom
	typedef logic [127:0] cheat_code_t;

	typedef logic [7:0]  cd_byte_t;
	typedef logic [14:0] cd_len_t;

	////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////

	localparam int ROM_ADDR_W = 24;

	// Compared against the low six index bits only
	localparam logic [5:0] IDX_CART_MAX = 6'h01;
	localparam logic [5:0] IDX_CD_DATA  = 6'h02;

	// Address bits above the 16-byte row holding the signature
	localparam logic [19:0] POP_PAGE_A = 20'h00212;
	localparam logic [19:0] POP_PAGE_B = 20'h001F2;

	// Expected words at row offsets 6, 8, 10, 12
	localparam io_word_t POP_SIG_0 = 16'h4F50;
	localparam io_word_t POP_SIG_1 = 16'h5550;
	localparam io_word_t POP_SIG_2 = 16'h4F4C;
	localparam io_word_t POP_SIG_3 = 16'h5355;

endpackage
